// File: dv/keystone_checker.sv
////////////////////////////////////////////////////////////
// Reply checker for the keystone core
// Shadows frame writes and H loads, compares each reply
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "keystone_consts.svh"

module keystone_checker (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  pixel_write,
    input  keystone_pkg::coord_t  write_x,
    input  keystone_pkg::coord_t  write_y,
    input  keystone_pkg::pixel_t  write_pixel,
    input  logic                  h_load,
    input  keystone_pkg::h_coef_t h_a,
    input  keystone_pkg::h_coef_t h_b,
    input  keystone_pkg::h_coef_t h_c,
    input  keystone_pkg::h_coef_t h_d,
    input  keystone_pkg::h_coef_t h_e,
    input  keystone_pkg::h_coef_t h_f,
    input  keystone_pkg::h_coef_t h_g,
    input  keystone_pkg::h_coef_t h_h,
    input  logic                  req,
    input  keystone_pkg::coord_t  dest_x,
    input  keystone_pkg::coord_t  dest_y,
    input  logic                  ack,
    input  keystone_pkg::pixel_t  pixel_out,
    output int                    error_count,
    output int                    reply_count
);
    import keystone_pkg::*;

    // Shadow copies of the source frame and of H, a to h
    pixel_t  frame [`FRAME_HEIGHT][`FRAME_WIDTH];
    h_coef_t coef [8];
    coord_t  req_x, req_y;
    logic    req_q, ack_q;
    pixel_t  held_pixel;
    pixel_t  expected;

    // n / d for d > 0, nearest integer, halves away from zero
    function automatic longint round_half_away(input longint n, input longint d);
        longint mag;
        longint q;
        mag = (n < 0) ? -n : n;
        q = mag / d;
        if (2 * (mag % d) >= d) q = q + 1;
        return (n < 0) ? -q : q;
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic pixel_t expected_pixel(input longint x, input longint y);
        longint xw, yw, w, xs, ys;
        // Q8.8 coefficients times integer coordinates, all in 1/256 units
        xw = coef[0] * x + coef[1] * y + coef[2];
        yw = coef[3] * x + coef[4] * y + coef[5];
        w  = coef[6] * x + coef[7] * y + `FIXED_ONE;
        // Point behind the projection
        if (w <= 0) return '0;
        xs = round_half_away(xw, w);
        ys = round_half_away(yw, w);
        if (xs < 0 || xs >= `FRAME_WIDTH || ys < 0 || ys >= `FRAME_HEIGHT) return '0;
        return frame[int'(ys)][int'(xs)];
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            // Controller comes out of reset with H all zero
            for (int i = 0; i < 8; i++) coef[i] <= '0;
            req_q       <= 1'b0;
            ack_q       <= 1'b0;
            error_count <= 0;
            reply_count <= 0;
        end else begin
            req_q <= req;
            ack_q <= ack;
            if (pixel_write && write_x >= 0 && write_x < `FRAME_WIDTH
                && write_y >= 0 && write_y < `FRAME_HEIGHT) begin
                frame[int'(write_y)][int'(write_x)] <= write_pixel;
            end
            if (h_load) begin
                coef[0] <= h_a;
                coef[1] <= h_b;
                coef[2] <= h_c;
                coef[3] <= h_d;
                coef[4] <= h_e;
                coef[5] <= h_f;
                coef[6] <= h_g;
                coef[7] <= h_h;
            end
            // Destination is stable from req rising until ack
            if (req && !req_q) begin
                req_x <= dest_x;
                req_y <= dest_y;
            end
            if (ack && !ack_q) begin
                expected = expected_pixel(req_x, req_y);
                held_pixel  <= pixel_out;
                reply_count <= reply_count + 1;
                if (!req) begin
                    $display("ack rose at %0t without a pending request", $time);
                    error_count <= error_count + 1;
                end else if (pixel_out !== expected) begin
                    $display("MISMATCH at %0t: pixel at (%0d,%0d) is %06h, expected %06h",
                             $time, req_x, req_y, pixel_out, expected);
                    error_count <= error_count + 1;
                end
            end else if (ack && pixel_out !== held_pixel) begin
                // Reply must hold while the host keeps req high
                $display("MISMATCH at %0t: pixel_out moved to %06h during ack, held %06h",
                         $time, pixel_out, held_pixel);
                error_count <= error_count + 1;
            end
        end
    end

endmodule : keystone_checker

`default_nettype wire

// File: dv/keystone_tb.sv
////////////////////////////////////////////////////////////
// Keystone core testbench with clock, reset, timeout,
// frame fill, H loads and pixel requests
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "keystone_consts.svh"

module keystone_tb;
    import keystone_pkg::*;

    localparam int ID_REQS     = 16;
    localparam int TR_REQS     = 24;
    localparam int RND_REQS    = 48;
    localparam int WNEG_REQS   = 16;
    localparam int RELOAD_REQS = 8;
    localparam int REQUESTS    = 1 + ID_REQS + TR_REQS + RND_REQS + WNEG_REQS + RELOAD_REQS;
    localparam int WRITES      = `FRAME_WIDTH * `FRAME_HEIGHT + 3;
    localparam int ACK_WAIT    = `DIV_STEPS + 20;
    localparam int CYCLE_LIMIT = WRITES + REQUESTS * ACK_WAIT + 2000;

    logic    clock, reset, pixel_write, h_load, req, ack;
    coord_t  write_x, write_y, dest_x, dest_y;
    pixel_t  write_pixel, pixel_out;
    h_coef_t h_a, h_b, h_c, h_d, h_e, h_f, h_g, h_h;
    int      check_errors, replies, tb_errors, errors_before, tests_done;
    int      cycle_count, total_errors;
    logic [31:0] rand_state;

    keystone_top uut (.*);

    keystone_checker watcher (.*, .error_count(check_errors), .reply_count(replies));

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // Run limit scaled from the number of writes and requests
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Random numbers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] rand_word();
        rand_state = lcg_next(rand_state);
        return rand_state;
    endfunction

    // Upper bits only since the low LCG bits have short periods
    function int rand_below(input int n);
        return int'(rand_word() >> 8) % n;
    endfunction

    function int rand_signed(input int span);
        return rand_below(2 * span + 1) - span;
    endfunction

    ////////////////////////////////////////////////////////////
    // Host side
    ////////////////////////////////////////////////////////////
    task automatic write_one(input int x, input int y, input logic [23:0] p);
        @(posedge clock);
        #1;
        pixel_write = 1'b1;
        write_x     = coord_t'(x);
        write_y     = coord_t'(y);
        write_pixel = p;
    endtask

    task automatic load_h(input int a, input int b, input int c, input int d,
                          input int e, input int f, input int g, input int h);
        @(posedge clock);
        #1;
        {h_a, h_b, h_c, h_d} = {h_coef_t'(a), h_coef_t'(b), h_coef_t'(c), h_coef_t'(d)};
        {h_e, h_f, h_g, h_h} = {h_coef_t'(e), h_coef_t'(f), h_coef_t'(g), h_coef_t'(h)};
        h_load = 1'b1;
        @(posedge clock);
        #1;
        h_load = 1'b0;
    endtask

    // Full four-phase exchange
    // The hold count keeps req high for that many cycles after ack
    task automatic request_pixel(input int x, input int y, input int hold);
        int waited;
        @(posedge clock);
        #1;
        dest_x = coord_t'(x);
        dest_y = coord_t'(y);
        req    = 1'b1;
        waited = 0;
        while (!ack && waited < ACK_WAIT) begin
            @(posedge clock);
            waited++;
        end
        if (!ack) begin
            $display("No ack within %0d cycles for request at (%0d,%0d)", ACK_WAIT, x, y);
            tb_errors++;
        end
        repeat (hold) @(posedge clock);
        #1;
        req    = 1'b0;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
        end while (ack && waited < 4);
        if (ack) begin
            $display("ack still high %0d cycles after req fell at (%0d,%0d)", waited, x, y);
            tb_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = check_errors + tb_errors - errors_before;
        $display("test %s: %0d errors", name, errs);
        errors_before = check_errors + tb_errors;
        tests_done++;
    endtask

    initial begin
        rand_state  = 32'h16e3_e3f6;
        reset       = 1'b1;
        pixel_write = 1'b0;
        write_x     = '0;
        write_y     = '0;
        write_pixel = '0;
        h_load      = 1'b0;
        {h_a, h_b, h_c, h_d, h_e, h_f, h_g, h_h} = '0;
        req         = 1'b0;
        dest_x      = '0;
        dest_y      = '0;
        {tb_errors, errors_before, tests_done, cycle_count} = '0;
        repeat (8) @(posedge clock);
        #1 reset = 1'b0;

        // Source frame and then writes just outside it that must be dropped
        for (int y = 0; y < `FRAME_HEIGHT; y++)
            for (int x = 0; x < `FRAME_WIDTH; x++) write_one(x, y, rand_word() >> 8);
        write_one(`FRAME_WIDTH, 0, 24'hffffff);
        write_one(0, `FRAME_HEIGHT, 24'hffffff);
        write_one(-1, 3, 24'hffffff);
        @(posedge clock);
        #1 pixel_write = 1'b0;

        // ack stays quiet while req is low
        repeat (10) begin
            @(posedge clock);
            if (ack) begin
                $display("ack high while req is low after reset");
                tb_errors++;
            end
        end
        // H is still zero here and maps every request to (0,0)
        request_pixel(5, 5, 0);
        finish_test("reset and handshake");

        load_h(`FIXED_ONE, 0, 0, 0, `FIXED_ONE, 0, 0, 0);
        request_pixel(0, 0, 0);
        request_pixel(`FRAME_WIDTH - 1, `FRAME_HEIGHT - 1, 0);
        for (int i = 2; i < ID_REQS; i++)
            request_pixel(rand_below(`FRAME_WIDTH), rand_below(`FRAME_HEIGHT), 0);
        finish_test("identity");

        // Shift by (+3.5, -1.5) and later by whole pixels (-5, +2)
        // Row 1 lands on -0.5, which rounds away from zero out of the frame
        load_h(`FIXED_ONE, 0, 896, 0, `FIXED_ONE, -384, 0, 0);
        for (int i = 0; i < TR_REQS; i++) begin
            if (i == TR_REQS / 2) load_h(`FIXED_ONE, 0, -1280, 0, `FIXED_ONE, 512, 0, 0);
            request_pixel(rand_below(`FRAME_WIDTH),
                          (i == 0) ? 1 : rand_below(`FRAME_HEIGHT), 0);
        end
        finish_test("translation");

        for (int i = 0; i < RND_REQS; i++) begin
            // Fresh perspective H every twelve requests with small g and h
            if (i % 12 == 0)
                load_h(`FIXED_ONE + rand_signed(64), rand_signed(48), rand_signed(1024),
                       rand_signed(48), `FIXED_ONE + rand_signed(64), rand_signed(1024),
                       rand_signed(4), rand_signed(6));
            request_pixel(rand_below(`FRAME_WIDTH), rand_below(`FRAME_HEIGHT), 0);
        end
        finish_test("random perspective");

        // w is not positive from x = 16, then from y = 11 for the second H
        // Small numerators put |xw / w| and |yw / w| inside the frame there
        load_h(0, 0, 512, 0, 0, 512, -16, 0);
        for (int i = 0; i < WNEG_REQS; i++) begin
            if (i == WNEG_REQS / 2) load_h(0, 0, 256, 0, 0, 256, 0, -24);
            request_pixel((i * 4) % `FRAME_WIDTH, (i < WNEG_REQS / 2) ?
                          rand_below(`FRAME_HEIGHT) : (i * 2) % `FRAME_HEIGHT, 0);
        end
        finish_test("w not positive");

        // Same destination under alternating H with some replies held long
        for (int i = 0; i < RELOAD_REQS; i++) begin
            if (i % 2 == 0) load_h(`FIXED_ONE, 0, 0, 0, `FIXED_ONE, 0, 0, 0);
            else load_h(`FIXED_ONE, 0, 512, 0, `FIXED_ONE, -256, 0, 0);
            request_pixel(10, 7, (i % 4 == 1) ? 30 : 0);
        end
        finish_test("reload and hold");

        total_errors = check_errors + tb_errors;
        $display("%0d tests, %0d replies, %0d errors", tests_done, replies, total_errors);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : keystone_tb

`default_nettype wire

// File: keystone.f
+incdir+logic
logic/keystone_pkg.sv
logic/rounding_divider.sv
logic/coordinate_calculator.sv
logic/frame_buffer.sv
logic/request_controller.sv
logic/keystone_top.sv
dv/keystone_checker.sv
dv/keystone_tb.sv

// File: logic/coordinate_calculator.sv
////////////////////////////////////////////////////////////
// Homography stage: two MAC stages, x and y dividers and
// the frame-range check on the source coordinates
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "keystone_consts.svh"

module coordinate_calculator (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  calc_start,
    input  keystone_pkg::h_coef_t coef_a,
    input  keystone_pkg::h_coef_t coef_b,
    input  keystone_pkg::h_coef_t coef_c,
    input  keystone_pkg::h_coef_t coef_d,
    input  keystone_pkg::h_coef_t coef_e,
    input  keystone_pkg::h_coef_t coef_f,
    input  keystone_pkg::h_coef_t coef_g,
    input  keystone_pkg::h_coef_t coef_h,
    input  keystone_pkg::coord_t  calc_x,
    input  keystone_pkg::coord_t  calc_y,
    output logic                  calc_done,
    output keystone_pkg::coord_t  src_x,
    output keystone_pkg::coord_t  src_y,
    output logic                  src_valid
);
    import keystone_pkg::*;

    acc_t   prod_ax, prod_by, prod_dx, prod_ey, prod_gx, prod_hy;
    acc_t   xw, yw, w;
    logic   products_valid;
    logic   div_start;
    logic   div_done_x, div_done_y;
    coord_t quot_x, quot_y;
    logic   w_positive, x_inside, y_inside;

    ////////////////////////////////////////////////////////////
    // Multiply-accumulate
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        // Stage one, Q8.8 times integer stays Q8.8
        if (calc_start) begin
            prod_ax <= coef_a * calc_x;
            prod_by <= coef_b * calc_y;
            prod_dx <= coef_d * calc_x;
            prod_ey <= coef_e * calc_y;
            prod_gx <= coef_g * calc_x;
            prod_hy <= coef_h * calc_y;
        end
        // Stage two, offsets and 1.0 already at Q8.8 scale
        if (products_valid) begin
            xw <= prod_ax + prod_by + acc_t'(coef_c);
            yw <= prod_dx + prod_ey + acc_t'(coef_f);
            w  <= prod_gx + prod_hy + acc_t'(`FIXED_ONE);
        end
        // Quotients held until the next start
        if (div_done_x && div_done_y) begin
            src_x <= quot_x;
            src_y <= quot_y;
        end
    end

    // Both axes share w, so both start and finish together
    rounding_divider div_x (
        .clock      (clock),
        .reset      (reset),
        .div_start  (div_start),
        .numerator  (xw),
        .denominator(w),
        .div_done   (div_done_x),
        .quotient   (quot_x)
    );

    rounding_divider div_y (
        .clock      (clock),
        .reset      (reset),
        .div_start  (div_start),
        .numerator  (yw),
        .denominator(w),
        .div_done   (div_done_y),
        .quotient   (quot_y)
    );

    // Point behind the projection or outside the source frame
    assign w_positive = !w[$bits(acc_t)-1] && (w != '0);
    assign x_inside   = (quot_x >= 0) && (quot_x < `FRAME_WIDTH);
    assign y_inside   = (quot_y >= 0) && (quot_y < `FRAME_HEIGHT);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            products_valid <= 1'b0;
            div_start      <= 1'b0;
            calc_done      <= 1'b0;
            src_valid      <= 1'b0;
        end else begin
            products_valid <= calc_start;
            div_start      <= products_valid;
            calc_done      <= div_done_x && div_done_y;
            if (div_done_x && div_done_y) src_valid <= w_positive && x_inside && y_inside;
        end
    end

endmodule : coordinate_calculator

`default_nettype wire

// File: logic/frame_buffer.sv
////////////////////////////////////////////////////////////
// Banked source frame memory
// One write port, one registered read port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "keystone_consts.svh"

module frame_buffer (
    input  logic                 clock,
    input  logic                 pixel_write,
    input  keystone_pkg::coord_t write_x,
    input  keystone_pkg::coord_t write_y,
    input  keystone_pkg::pixel_t write_pixel,
    input  logic                 read_en,
    input  keystone_pkg::coord_t read_x,
    input  keystone_pkg::coord_t read_y,
    output keystone_pkg::pixel_t read_pixel
);
    import keystone_pkg::*;

    localparam int BANK_LINES = `FRAME_HEIGHT / `BANK_ROWS;
    localparam int BANK_BITS  = $clog2(`BANK_ROWS);
    localparam int LINE_BITS  = $clog2(BANK_LINES);
    localparam int COL_BITS   = $clog2(`FRAME_WIDTH);
    localparam int BANK_DEPTH = BANK_LINES * `FRAME_WIDTH;

    logic                          write_inside;
    logic [BANK_BITS-1:0]          write_bank, read_bank, read_bank_q;
    logic [LINE_BITS+COL_BITS-1:0] write_addr, read_addr;
    pixel_t                        bank_data [`BANK_ROWS];

    // Drop writes that miss the frame
    assign write_inside = pixel_write && (write_x >= 0) && (write_x < `FRAME_WIDTH)
                          && (write_y >= 0) && (write_y < `FRAME_HEIGHT);

    // Low y bits pick the bank, upper y bits the line inside it
    assign write_bank = write_y[BANK_BITS-1:0];
    assign read_bank  = read_y[BANK_BITS-1:0];
    assign write_addr = {write_y[BANK_BITS +: LINE_BITS], write_x[COL_BITS-1:0]};
    assign read_addr  = {read_y[BANK_BITS +: LINE_BITS], read_x[COL_BITS-1:0]};

    for (genvar b = 0; b < `BANK_ROWS; b++) begin : g_bank
        pixel_t mem [BANK_DEPTH];

        always_ff @(posedge clock) begin
            if (write_inside && (write_bank == BANK_BITS'(b))) mem[write_addr] <= write_pixel;
            if (read_en && (read_bank == BANK_BITS'(b))) bank_data[b] <= mem[read_addr];
        end
    end

    // Remember which bank answered, output holds between reads
    always_ff @(posedge clock) begin
        if (read_en) read_bank_q <= read_bank;
    end

    assign read_pixel = bank_data[read_bank_q];

endmodule : frame_buffer

`default_nettype wire

// File: logic/keystone_consts.svh
////////////////////////////////////////////////////////////
// Frame geometry, fixed-point format and divider length
// shared by the keystone correction core
////////////////////////////////////////////////////////////

`ifndef KEYSTONE_CONSTS_SVH
`define KEYSTONE_CONSTS_SVH

// Source frame size in pixels
`define FRAME_WIDTH 32
`define FRAME_HEIGHT 16

// Row banks of the frame buffer, bank = y mod BANK_ROWS
`define BANK_ROWS 4

// Q8.8 coefficients
`define FRAC_BITS 8
`define FIXED_ONE 256

// Restoring divider iterations
// One quotient bit per step
`define DIV_STEPS 40

`endif

// File: logic/keystone_pkg.sv
////////////////////////////////////////////////////////////
// Shared types of the keystone core
// Coordinates, coefficients, accumulators, pixels, states
////////////////////////////////////////////////////////////

`default_nettype none

package keystone_pkg;

    // Signed pixel coordinate
    typedef logic signed [15:0] coord_t;

    // Signed Q8.8 homography coefficient
    typedef logic signed [15:0] h_coef_t;

    // Multiply-accumulate sum, wide enough for three Q8.8 terms
    typedef logic signed [39:0] acc_t;

    // Packed color, red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] pixel_t;

    // Request controller states
    typedef enum logic [1:0] {IDLE, CALC, FETCH, REPLY} ctrl_state_t;

    // Serial divider states
    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_t;

endpackage : keystone_pkg

`default_nettype wire

// File: logic/keystone_top.sv
////////////////////////////////////////////////////////////
// Keystone correction core top level
// Controller, coordinate calculator and frame buffer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module keystone_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  pixel_write,
    input  keystone_pkg::coord_t  write_x,
    input  keystone_pkg::coord_t  write_y,
    input  keystone_pkg::pixel_t  write_pixel,
    input  logic                  h_load,
    input  keystone_pkg::h_coef_t h_a,
    input  keystone_pkg::h_coef_t h_b,
    input  keystone_pkg::h_coef_t h_c,
    input  keystone_pkg::h_coef_t h_d,
    input  keystone_pkg::h_coef_t h_e,
    input  keystone_pkg::h_coef_t h_f,
    input  keystone_pkg::h_coef_t h_g,
    input  keystone_pkg::h_coef_t h_h,
    input  logic                  req,
    input  keystone_pkg::coord_t  dest_x,
    input  keystone_pkg::coord_t  dest_y,
    output logic                  ack,
    output keystone_pkg::pixel_t  pixel_out
);
    import keystone_pkg::*;

    // Controller to calculator
    logic    calc_start, calc_done, src_valid;
    h_coef_t coef_a, coef_b, coef_c, coef_d, coef_e, coef_f, coef_g, coef_h;
    coord_t  calc_x, calc_y, src_x, src_y;

    // Controller to frame buffer
    logic    read_en;
    coord_t  read_x, read_y;
    pixel_t  read_pixel;

    request_controller u_ctrl (.*);

    coordinate_calculator u_calc (.*);

    frame_buffer u_frame (.*);

endmodule : keystone_top

`default_nettype wire

// File: logic/request_controller.sv
////////////////////////////////////////////////////////////
// Four-phase request FSM, H latch and
// black fallback on the returned color
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module request_controller (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  h_load,
    input  logic                  req,
    input  keystone_pkg::h_coef_t h_a,
    input  keystone_pkg::h_coef_t h_b,
    input  keystone_pkg::h_coef_t h_c,
    input  keystone_pkg::h_coef_t h_d,
    input  keystone_pkg::h_coef_t h_e,
    input  keystone_pkg::h_coef_t h_f,
    input  keystone_pkg::h_coef_t h_g,
    input  keystone_pkg::h_coef_t h_h,
    input  keystone_pkg::coord_t  dest_x,
    input  keystone_pkg::coord_t  dest_y,
    output logic                  calc_start,
    output keystone_pkg::h_coef_t coef_a,
    output keystone_pkg::h_coef_t coef_b,
    output keystone_pkg::h_coef_t coef_c,
    output keystone_pkg::h_coef_t coef_d,
    output keystone_pkg::h_coef_t coef_e,
    output keystone_pkg::h_coef_t coef_f,
    output keystone_pkg::h_coef_t coef_g,
    output keystone_pkg::h_coef_t coef_h,
    output keystone_pkg::coord_t  calc_x,
    output keystone_pkg::coord_t  calc_y,
    input  logic                  calc_done,
    input  logic                  src_valid,
    input  keystone_pkg::coord_t  src_x,
    input  keystone_pkg::coord_t  src_y,
    output logic                  read_en,
    output keystone_pkg::coord_t  read_x,
    output keystone_pkg::coord_t  read_y,
    input  keystone_pkg::pixel_t  read_pixel,
    output logic                  ack,
    output keystone_pkg::pixel_t  pixel_out
);
    import keystone_pkg::*;

    localparam pixel_t BLACK = '0;

    ctrl_state_t state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            calc_start <= 1'b0;
            read_en    <= 1'b0;
            coef_a     <= '0;
            coef_b     <= '0;
            coef_c     <= '0;
            coef_d     <= '0;
            coef_e     <= '0;
            coef_f     <= '0;
            coef_g     <= '0;
            coef_h     <= '0;
        end else begin
            calc_start <= 1'b0;
            read_en    <= 1'b0;
            case (state)
                IDLE: begin
                    // H latch, only touched between requests
                    if (h_load) begin
                        coef_a <= h_a;
                        coef_b <= h_b;
                        coef_c <= h_c;
                        coef_d <= h_d;
                        coef_e <= h_e;
                        coef_f <= h_f;
                        coef_g <= h_g;
                        coef_h <= h_h;
                    end
                    if (req) begin
                        calc_start <= 1'b1;
                        state      <= CALC;
                    end
                end
                CALC: begin
                    // Skip the memory read for a black result
                    if (calc_done) begin
                        read_en <= src_valid;
                        state   <= FETCH;
                    end
                end
                FETCH: state <= REPLY;
                // Hold the reply until the host lets go of req
                REPLY: if (!req) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Request and lookup coordinates
    always_ff @(posedge clock) begin
        if ((state == IDLE) && req) begin
            calc_x <= dest_x;
            calc_y <= dest_y;
        end
        if ((state == CALC) && calc_done) begin
            read_x <= src_x;
            read_y <= src_y;
        end
    end

    assign ack       = (state == REPLY);
    assign pixel_out = src_valid ? read_pixel : BLACK;

endmodule : request_controller

`default_nettype wire

// File: logic/rounding_divider.sv
////////////////////////////////////////////////////////////
// Serial restoring divider with round half away from zero
// and saturation of the quotient to a coordinate
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none
`include "keystone_consts.svh"

module rounding_divider (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 div_start,
    input  keystone_pkg::acc_t   numerator,
    input  keystone_pkg::acc_t   denominator,
    output logic                 div_done,
    output keystone_pkg::coord_t quotient
);
    import keystone_pkg::*;

    localparam int STEPS      = `DIV_STEPS;
    localparam int CNT_BITS   = $clog2(STEPS);
    localparam int MAG_BITS   = $bits(acc_t);
    localparam int REM_BITS   = MAG_BITS + 3;
    localparam int COORD_BITS = $bits(coord_t);
    localparam int COORD_MAX  = 2 ** (COORD_BITS - 1) - 1;

    div_state_t                state;
    logic [CNT_BITS-1:0]       step_count;
    logic [STEPS-1:0]          quo_shift;
    logic [REM_BITS-1:0]       rem;
    logic [REM_BITS-1:0]       divisor;
    logic                      result_neg;
    logic [MAG_BITS-1:0]       num_mag;
    logic [MAG_BITS-1:0]       den_mag;
    logic [REM_BITS-1:0]       dividend;
    logic [REM_BITS-1:0]       rem_shift;
    logic                      rem_fits;
    logic [COORD_BITS-1:0]     clipped_mag;

    // Magnitudes of both operands
    assign num_mag = numerator[MAG_BITS-1] ? -numerator : numerator;
    assign den_mag = denominator[MAG_BITS-1] ? -denominator : denominator;

    // floor((2|N| + |D|) / 2|D|) gives |N|/|D| rounded half up
    assign dividend = {2'b00, num_mag, 1'b0} + {3'b000, den_mag};

    // One restoring step: shift in next dividend bit, try subtract
    assign rem_shift = {rem[REM_BITS-2:0], quo_shift[STEPS-1]};
    assign rem_fits  = (rem_shift >= divisor);

    // Clip magnitude to the largest positive coordinate
    assign clipped_mag = (quo_shift > STEPS'(COORD_MAX)) ?
                         COORD_BITS'(COORD_MAX) : quo_shift[COORD_BITS-1:0];

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= DIV_IDLE;
            step_count <= '0;
            div_done   <= 1'b0;
        end else begin
            div_done <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (div_start) begin
                        step_count <= '0;
                        state      <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    step_count <= step_count + 1'b1;
                    if (step_count == CNT_BITS'(STEPS - 1)) state <= DIV_DONE;
                end
                DIV_DONE: begin
                    div_done <= 1'b1;
                    state    <= DIV_IDLE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        case (state)
            DIV_IDLE: begin
                if (div_start) begin
                    // Accumulator range keeps the dividend inside STEPS bits
                    quo_shift  <= dividend[STEPS-1:0];
                    rem        <= '0;
                    divisor    <= {2'b00, den_mag, 1'b0};
                    result_neg <= numerator[MAG_BITS-1];
                end
            end
            DIV_RUN: begin
                rem       <= rem_fits ? rem_shift - divisor : rem_shift;
                quo_shift <= {quo_shift[STEPS-2:0], rem_fits};
            end
            DIV_DONE: begin
                // Sign of the numerator, so halves round away from zero
                quotient <= result_neg ? -coord_t'(clipped_mag) : coord_t'(clipped_mag);
            end
            default: ;
        endcase
    end

endmodule : rounding_divider

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the keystone testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module keystone_tb -Mdir obj_dir -f keystone.f
./obj_dir/Vkeystone_tb | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1
